/* source/host_reg_pkg.sv */
// host register map
// address constants and the write stream seen by the host register file
`default_nettype none

package host_reg_pkg;

  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  // one beat of the host write stream, write is a single-cycle strobe
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t data;
    logic      write;
  } reg_wr_t;

  // held buttons, console order
  localparam reg_addr_t REG_BTN_P1 = 8'h40;
  localparam reg_addr_t REG_BTN_P2 = 8'h41;

endpackage

`default_nettype wire

/* source/nes_pad_pkg.sv */
// controller types
// console button byte, raw pad bytes and the bit positions inside each
`default_nettype none

package nes_pad_pkg;

  localparam int NUM_PORTS = 2;  // console controller ports

  // console order from bit 7: right left down up start select B A
  typedef logic [7:0] nes_btn_t;
  typedef logic [7:0] pad_byte_t;  // raw pad byte, active low

  typedef struct packed {
    pad_byte_t dir_byte;   // d-pad, start, sticks, select
    pad_byte_t face_byte;  // face buttons and shoulders
  } pad_raw_t;

  // dir_byte bits
  localparam int DIR_LEFT   = 7;
  localparam int DIR_DOWN   = 6;
  localparam int DIR_RIGHT  = 5;
  localparam int DIR_UP     = 4;
  localparam int DIR_START  = 3;
  localparam int DIR_RSTICK = 2;
  localparam int DIR_LSTICK = 1;
  localparam int DIR_SELECT = 0;

  // face_byte bits
  localparam int FACE_SQUARE   = 7;
  localparam int FACE_CROSS    = 6;
  localparam int FACE_CIRCLE   = 5;
  localparam int FACE_TRIANGLE = 4;
  localparam int FACE_R1       = 3;
  localparam int FACE_L1       = 2;
  localparam int FACE_R2       = 1;
  localparam int FACE_L2       = 0;

  // console button bits, A goes out first on the serial line
  localparam int NES_RIGHT  = 7;
  localparam int NES_LEFT   = 6;
  localparam int NES_DOWN   = 5;
  localparam int NES_UP     = 4;
  localparam int NES_START  = 3;
  localparam int NES_SELECT = 2;
  localparam int NES_B      = 1;
  localparam int NES_A      = 0;

endpackage

`default_nettype wire

/* source/host_regs.sv */
// host button registers
// decodes the host write stream and keeps one held-button byte per player
`timescale 1ns/10ps
`default_nettype none

module host_regs
  import host_reg_pkg::*;
  import nes_pad_pkg::*;
(
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  reg_wr_t                     wr,
  output nes_btn_t [NUM_PORTS-1:0]    host_btn
);

  logic     wr_p1;
  logic     wr_p2;
  nes_btn_t wr_btn;

  // address decode, anything else falls through
  assign wr_p1  = wr.write && (wr.addr == REG_BTN_P1);
  assign wr_p2  = wr.write && (wr.addr == REG_BTN_P2);
  assign wr_btn = nes_btn_t'(wr.data);  // host already sends console order

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      host_btn <= '0;
    end else begin
      if (wr_p1) begin
        host_btn[0] <= wr_btn;
      end
      if (wr_p2) begin
        host_btn[1] <= wr_btn;
      end
    end
  end

endmodule

`default_nettype wire

/* source/autofire.sv */
// autofire
// square wave on out while btn is held, half-period AUTOFIRE_PERIOD clocks
`timescale 1ns/10ps
`default_nettype none

module autofire #(
  parameter int unsigned AUTOFIRE_PERIOD = 1_350_000
) (
  input  logic clk,
  input  logic sys_resetn,
  input  logic btn,
  output logic out
);

  localparam int CNT_W = $clog2(AUTOFIRE_PERIOD);

  logic [CNT_W-1:0] cnt;
  logic             cnt_wrap;

  assign cnt_wrap = (cnt == CNT_W'(AUTOFIRE_PERIOD - 1));

  always_ff @(posedge clk) begin
    if (!sys_resetn || !btn) begin
      cnt <= '0;  // release restarts from low
      out <= 1'b0;
    end else if (cnt_wrap) begin
      cnt <= '0;
      out <= ~out;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/pad_mapper.sv */
// pad mapper
// turns one pad's active-low raw bytes into console button order,
// square and triangle add autofire to B and A
`timescale 1ns/10ps
`default_nettype none

module pad_mapper
  import nes_pad_pkg::*;
#(
  parameter int unsigned AUTOFIRE_PERIOD = 1_350_000
) (
  input  logic     clk,
  input  logic     sys_resetn,
  input  pad_raw_t raw,
  output nes_btn_t btn
);

  pad_byte_t dir_on;   // high means pressed
  pad_byte_t face_on;
  logic      auto_square;
  logic      auto_triangle;
  nes_btn_t  mapped;

  assign dir_on  = ~raw.dir_byte;
  assign face_on = ~raw.face_byte;

  autofire #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) af_square_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (face_on[FACE_SQUARE]),
    .out        (auto_square)
  );

  autofire #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) af_triangle_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .btn        (face_on[FACE_TRIANGLE]),
    .out        (auto_triangle)
  );

  always_comb begin
    mapped             = '0;
    mapped[NES_RIGHT]  = dir_on[DIR_RIGHT];
    mapped[NES_LEFT]   = dir_on[DIR_LEFT];
    mapped[NES_DOWN]   = dir_on[DIR_DOWN];
    mapped[NES_UP]     = dir_on[DIR_UP];
    mapped[NES_START]  = dir_on[DIR_START];
    mapped[NES_SELECT] = dir_on[DIR_SELECT];
    // cross is B, circle is A
    mapped[NES_B]      = face_on[FACE_CROSS] | auto_square;
    mapped[NES_A]      = face_on[FACE_CIRCLE] | auto_triangle;
  end

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      btn <= '0;
    end else begin
      btn <= mapped;
    end
  end

endmodule

`default_nettype wire

/* source/joypad_port.sv */
// joypad port
// merges host, pad and parallel gamepad buttons and serves them
// bit-serially on the console strobe and clock lines
`timescale 1ns/10ps
`default_nettype none

module joypad_port
  import nes_pad_pkg::*;
(
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  nes_btn_t [NUM_PORTS-1:0]    host_btn,
  input  nes_btn_t [NUM_PORTS-1:0]    pad_btn,
  input  nes_btn_t                    gamepad_btn,
  input  logic     [NUM_PORTS-1:0]    joypad_strobe,
  input  logic     [NUM_PORTS-1:0]    joypad_clock,
  output logic     [NUM_PORTS-1:0]    joypad_data
);

  nes_btn_t [NUM_PORTS-1:0] merged;
  nes_btn_t [NUM_PORTS-1:0] shift_q;
  logic     [NUM_PORTS-1:0] last_clock;
  logic     [NUM_PORTS-1:0] clock_fall;
  logic                     latch;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      merged[p] = host_btn[p] | pad_btn[p];
    end
    merged[0] = merged[0] | gamepad_btn;  // parallel pad is player 1 only
  end

  // the console latch is shared, either line reloads both ports
  assign latch      = |joypad_strobe;
  assign clock_fall = last_clock & ~joypad_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      last_clock <= '0;
      shift_q    <= '0;
    end else begin
      last_clock <= joypad_clock;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (clock_fall[p]) begin
          shift_q[p] <= {1'b0, shift_q[p][7:1]};  // shift beats strobe
        end else if (latch) begin
          shift_q[p] <= merged[p];
        end
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      joypad_data[p] = shift_q[p][0];
    end
  end

endmodule

`default_nettype wire

/* source/pad_frontend_top.sv */
// controller front end
// host button registers, one mapper per pad and the serial joypad port
`timescale 1ns/10ps
`default_nettype none

module pad_frontend_top
  import host_reg_pkg::*;
  import nes_pad_pkg::*;
#(
  parameter int unsigned AUTOFIRE_PERIOD = 1_350_000
) (
  input  logic                        clk,
  input  logic                        sys_resetn,
  input  reg_wr_t                     wr,
  input  pad_raw_t [NUM_PORTS-1:0]    pad_raw,
  input  nes_btn_t                    gamepad_btn,
  input  logic     [NUM_PORTS-1:0]    joypad_strobe,
  input  logic     [NUM_PORTS-1:0]    joypad_clock,
  output logic     [NUM_PORTS-1:0]    joypad_data
);

  nes_btn_t [NUM_PORTS-1:0] host_btn;
  nes_btn_t [NUM_PORTS-1:0] pad_btn;  // mapped, console order

  host_regs host_regs_inst (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .wr         (wr),
    .host_btn   (host_btn)
  );

  // one mapper per player pad
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_mapper
    pad_mapper #(
      .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
    ) pad_mapper_inst (
      .clk        (clk),
      .sys_resetn (sys_resetn),
      .raw        (pad_raw[i]),
      .btn        (pad_btn[i])
    );
  end

  joypad_port joypad_port_inst (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .host_btn      (host_btn),
    .pad_btn       (pad_btn),
    .gamepad_btn   (gamepad_btn),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

endmodule

`default_nettype wire

/* include/pad_check_tasks.svh */
// compare helpers for the controller testbench
// typed checks for button bytes and single bits plus pass and fail tallies
`ifndef PAD_CHECK_TASKS_SVH
`define PAD_CHECK_TASKS_SVH

int pass_count = 0;
int fail_count = 0;

// whole console byte
task automatic match_btn(input string what, input nes_btn_t got, input nes_btn_t exp);
  if (got !== exp) begin
    fail_count++;
    $display("FAILED %s: got 0x%02h expected 0x%02h", what, got, exp);
  end else begin
    pass_count++;
  end
endtask

// one serial bit where X counts as a miss
task automatic verify_bit(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    fail_count++;
    $display("FAILED %s: got 0x%01h expected 0x%01h", what, got, exp);
  end else begin
    pass_count++;
  end
endtask

`endif

/* bench/pad_frontend_tb.sv */
// controller front end testbench
// replays the case file against the top level and reads both joypad
// ports back bit by bit after each strobe
`timescale 1ns/10ps
`default_nettype none

module pad_frontend_tb
  import host_reg_pkg::*;
  import nes_pad_pkg::*;
();

  localparam int unsigned AUTOFIRE_PERIOD = 4;
  localparam int MAX_CASES = 32;

  // one line of the case file with the first column in the top bits
  typedef struct packed {
    logic [7:0] reps;     // strobe readouts in this case
    nes_btn_t   mask_p1;  // bits that autofire must toggle
    nes_btn_t   mask_p2;
    reg_addr_t  addr1;
    reg_data_t  data1;
    reg_addr_t  addr2;
    reg_data_t  data2;
    pad_raw_t   raw_p1;
    pad_raw_t   raw_p2;
    nes_btn_t   gamepad;
    nes_btn_t   exp_p1;
    nes_btn_t   exp_p2;
  } case_t;

  logic                     clk;
  logic                     sys_resetn;
  reg_wr_t                  wr;
  pad_raw_t [NUM_PORTS-1:0] pad_raw;
  nes_btn_t                 gamepad_btn;
  logic     [NUM_PORTS-1:0] joypad_strobe;
  logic     [NUM_PORTS-1:0] joypad_clock;
  logic     [NUM_PORTS-1:0] joypad_data;

  logic [$bits(case_t)-1:0] case_mem [MAX_CASES];
  nes_btn_t [NUM_PORTS-1:0] held;  // host registers as the bench expects them
  int                       num_cases;
  int                       cycles = 0;
  int                       cycle_limit = 1000;  // reset and idle margin

  `include "pad_check_tasks.svh"

  pad_frontend_top #(
    .AUTOFIRE_PERIOD(AUTOFIRE_PERIOD)
  ) pad_frontend_top_inst (
    .clk           (clk),
    .sys_resetn    (sys_resetn),
    .wr            (wr),
    .pad_raw       (pad_raw),
    .gamepad_btn   (gamepad_btn),
    .joypad_strobe (joypad_strobe),
    .joypad_clock  (joypad_clock),
    .joypad_data   (joypad_data)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // console order R L D U start select B A from active-low raw bits
  function automatic nes_btn_t console_order(input pad_raw_t raw);
    logic [7:0] d;
    logic [7:0] f;
    d = ~raw.dir_byte;
    f = ~raw.face_byte;
    return {d[5], d[7], d[6], d[4], d[3], d[0], f[6], f[5]};
  endfunction

  // one write pulse that is also mirrored into held
  task automatic send_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge clk);
    wr.addr  = addr;
    wr.data  = data;
    wr.write = 1'b1;
    if (addr == 8'h40) begin
      held[0] = data;
    end else if (addr == 8'h41) begin
      held[1] = data;
    end
  endtask

  // strobe and then ten falls per port with the two clocks interleaved
  task automatic read_ports(input nes_btn_t [NUM_PORTS-1:0] exp,
                            input nes_btn_t [NUM_PORTS-1:0] mask,
                            output nes_btn_t [NUM_PORTS-1:0] got);
    string name;
    got = '0;
    @(negedge clk);
    joypad_strobe = '1;
    @(negedge clk);
    joypad_strobe = '0;
    @(negedge clk);
    for (int i = 0; i < 10; i++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        name = $sformatf("joypad_data[%0d] bit %0d", p, i);
        if (i > 7) begin
          verify_bit(name, joypad_data[p], 1'b0);  // past the last button
        end else begin
          got[p][i] = joypad_data[p];
          if (!mask[p][i]) begin
            verify_bit(name, joypad_data[p], exp[p][i]);
          end
        end
        joypad_clock[p] = 1'b0;
        @(negedge clk);
        joypad_clock[p] = 1'b1;
        @(negedge clk);
      end
    end
  endtask

  task automatic run_case(input int idx, input case_t c);
    nes_btn_t [NUM_PORTS-1:0] exp;
    nes_btn_t [NUM_PORTS-1:0] mask;
    nes_btn_t [NUM_PORTS-1:0] model;
    nes_btn_t [NUM_PORTS-1:0] got;
    nes_btn_t [NUM_PORTS-1:0] seen_hi;
    nes_btn_t [NUM_PORTS-1:0] seen_lo;
    int                       fails_before;
    fails_before = fail_count;
    exp     = {c.exp_p2, c.exp_p1};
    mask    = {c.mask_p2, c.mask_p1};
    seen_hi = '0;
    seen_lo = '0;
    send_write(c.addr1, c.data1);
    pad_raw[0]  = c.raw_p1;
    pad_raw[1]  = c.raw_p2;
    gamepad_btn = c.gamepad;
    send_write(c.addr2, c.data2);
    @(negedge clk);
    wr.write = 1'b0;
    repeat (4) @(negedge clk);  // registers and mapper settle

    // merge rule with the parallel pad on port 0 only
    model[0] = held[0] | console_order(c.raw_p1) | c.gamepad;
    model[1] = held[1] | console_order(c.raw_p2);
    for (int p = 0; p < NUM_PORTS; p++) begin
      if ((model[p] & ~mask[p]) != (exp[p] & ~mask[p])) begin
        fail_count++;
        $display("case %0d: expected byte for port %0d does not follow the merge rule",
                 idx, p);
      end
    end

    for (int r = 0; r < int'(c.reps); r++) begin
      repeat ($urandom % 8) @(negedge clk);  // vary the autofire phase
      read_ports(exp, mask, got);
      for (int p = 0; p < NUM_PORTS; p++) begin
        match_btn($sformatf("joypad_data[%0d] byte", p), got[p] & ~mask[p], exp[p] & ~mask[p]);
      end
      seen_hi = seen_hi | (got & mask);
      seen_lo = seen_lo | (~got & mask);
    end
    if (seen_hi != mask || seen_lo != mask) begin
      fail_count++;
      $display("case %0d: an autofire button never toggled over %0d readouts", idx, c.reps);
    end
    $display("case %0d: %0d errors", idx, fail_count - fails_before);
  endtask

  initial begin
    case_t c;
    sys_resetn    = 1'b0;
    wr            = '0;
    pad_raw       = '1;  // nothing pressed
    gamepad_btn   = '0;
    joypad_strobe = '0;
    joypad_clock  = '1;  // console clocks idle high
    held          = '0;
    num_cases     = 0;
    void'($urandom(74));

    for (int i = 0; i < MAX_CASES; i++) begin
      case_mem[i] = '0;
    end
    $readmemh("bench/joypad_cases.txt", case_mem);
    for (int i = 0; i < MAX_CASES; i++) begin
      c = case_t'(case_mem[i]);
      if (c.reps != 0 && num_cases == i) begin
        num_cases++;
        cycle_limit = cycle_limit + int'(c.reps) * 64 + 16;
      end
    end
    if (num_cases == 0) begin
      fail_count++;
      $display("no cases could be read from bench/joypad_cases.txt");
    end

    repeat (2) @(negedge clk);
    sys_resetn = 1'b1;
    @(negedge clk);
    for (int p = 0; p < NUM_PORTS; p++) begin
      verify_bit($sformatf("joypad_data[%0d] after reset", p), joypad_data[p], 1'b0);
    end

    for (int i = 0; i < num_cases; i++) begin
      run_case(i + 1, case_t'(case_mem[i]));
    end

    $display("%0d cases, %0d checks passed, %0d failed", num_cases, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/joypad_cases.txt */
// reps mask_p1 mask_p2 addr1 data1 addr2 data2 p1_dir p1_face p2_dir p2_face gamepad exp_p1 exp_p2
// raw pad bytes are active low, masks mark console bits that autofire must toggle
01_00_00_00_00_00_00_ff_ff_ff_ff_00_00_00 // idle after reset
02_00_00_00_00_00_00_df_ff_7f_ff_00_80_40 // right on p1, left on p2
02_00_00_00_00_00_00_e7_ff_be_ff_00_18_24 // up start, down select
02_00_00_00_00_00_00_f9_b0_ff_df_00_02_01 // cross, circle, sticks and shoulders dropped
02_00_00_00_00_00_00_00_ff_ff_9f_00_fc_03 // whole dir byte, cross and circle
02_00_00_40_a5_00_ff_ff_ff_ff_ff_00_a5_00 // host p1, write to 00 ignored
02_00_00_41_3c_22_ff_ff_ff_ff_ff_00_a5_3c // host p2, write to 22 ignored
02_00_00_40_00_7f_55_df_ff_7f_ff_00_80_7c // host p1 cleared, host p2 ORed with pad
02_00_00_41_00_00_00_ff_ff_ff_ff_81_81_00 // parallel pad on port 0 only
02_00_00_40_10_00_00_ff_bf_df_ff_02_12_80 // host, pad and parallel pad merged
01_00_00_40_00_41_00_ff_ff_ff_ff_00_00_00 // everything cleared
10_02_01_00_00_00_00_ff_7f_ff_ef_00_00_00 // square on p1, triangle on p2 held
10_00_00_00_00_00_00_ff_ff_ff_ff_00_00_00 // turbo released
04_00_00_00_00_00_00_ff_3f_ff_ff_00_02_00 // cross keeps B high under square
02_00_00_40_ff_41_ff_ff_ff_ff_ff_00_ff_ff // both host registers full

/* sources.f */
+incdir+include
source/host_reg_pkg.sv
source/nes_pad_pkg.sv
source/host_regs.sv
source/autofire.sv
source/pad_mapper.sv
source/joypad_port.sv
source/pad_frontend_top.sv
bench/pad_frontend_tb.sv

/* Makefile */
# Verilator build, run and lint for the controller front end

SIM = obj_dir/Vpad_frontend_tb

.PHONY: all run lint clean

all: run

$(SIM): sources.f $(wildcard source/*.sv) $(wildcard bench/*.sv) $(wildcard include/*.svh)
	verilator --binary --timing -Wno-fatal --top-module pad_frontend_tb -f sources.f -Mdir obj_dir

# the log decides pass or fail
run: $(SIM) bench/joypad_cases.txt
	./$(SIM) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

lint:
	verilator --lint-only --timing --top-module pad_frontend_tb -f sources.f

clean:
	rm -rf obj_dir sim.log
